// File: common/sccb_pkg.sv
package sccb_pkg;

        // one byte on the wire
        typedef logic [7:0] sccb_byte_t;

        // primitives the byte engine understands
        typedef enum logic [2:0] {
                idle,
                start,
                write_byte,
                read_byte_nack,
                stop
        } sccb_cmd_e;

        // 50 us scl half period in clocks
        localparam int half_bit_cycles = 5;
        localparam int half_cnt_w = $clog2(half_bit_cycles);

        typedef logic [half_cnt_w-1:0] half_cnt_t;

endpackage

// File: common/cam_cfg_pkg.sv
package cam_cfg_pkg;

        typedef logic [7:0] reg_addr_t;
        typedef logic [7:0] reg_val_t;
        typedef logic [4:0] cfg_idx_t;

        localparam int cfg_entries = 32;

        // read address is this with bit 0 set
        localparam logic [7:0] device_addr = 8'h42;

        localparam reg_addr_t reg_com7 = 8'h12;
        localparam reg_val_t reset_cmd = 8'h80; // soft reset bit in com7
        localparam reg_addr_t reg_ver = 8'h0B;
        localparam reg_addr_t reg_pid = 8'h0A;

        // delay kinds between transactions
        typedef enum logic [1:0] {
                gap_byte,
                gap_cfg,
                gap_settle
        } gap_e;

        typedef logic [12:0] gap_cnt_t;

        // 100 us, 2 ms, 50 ms
        localparam gap_cnt_t gap_cycles [0:2] = '{13'd10, 13'd200, 13'd5000};

        // end of init report
        localparam logic [7:0] marker_cr = 8'h0D;
        localparam logic [7:0] marker_lf = 8'h0A;

endpackage

// File: sccb/sccb_byte_engine.sv
`timescale 1ns/100ps

module sccb_byte_engine import sccb_pkg::*; (
        input  logic       clk_100kHz,
        input  logic       rst_n,
        input  sccb_cmd_e  cmd,
        input  sccb_byte_t tx_byte,
        output logic       done,
        output sccb_byte_t rx_byte,
        output logic       scl,
        output logic       sda_out,
        output logic       sda_oe,
        input  logic       sda_in
);

        sccb_cmd_e op;
        sccb_cmd_e cur;
        half_cnt_t half_cnt;
        logic [4:0] slot; // half-bit index inside the primitive
        logic [4:0] nslot;
        logic [4:0] last_slot;
        logic [3:0] nbit;
        logic accept;
        logic last_half;
        sccb_byte_t shreg;

        assign accept = (op == idle) && (cmd != idle);
        assign last_half = (half_cnt == half_cnt_t'(half_bit_cycles - 1));
        assign nslot = accept ? 5'd0 : slot + 5'd1;
        assign nbit = nslot[4:1];
        assign last_slot = (op == start || op == stop) ? 5'd2 : 5'd17;
        assign rx_byte = shreg;

        always_comb begin
                if (accept)
                        cur = cmd;
                else
                        cur = op;
        end

        always_ff @(posedge clk_100kHz or negedge rst_n) begin
                if (!rst_n) begin
                        op <= idle;
                        half_cnt <= '0;
                        slot <= '0;
                        done <= 1'b0;
                        scl <= 1'b1;
                        sda_out <= 1'b1;
                        sda_oe <= 1'b1;
                        shreg <= '0;
                end else begin
                        done <= 1'b0;
                        if (op != idle && last_half && slot == last_slot) begin
                                op <= idle;
                                done <= 1'b1;
                                if (op == write_byte || op == read_byte_nack)
                                        scl <= 1'b0; // park scl low between bytes
                        end else if (accept || (op != idle && last_half)) begin
                                op <= cur;
                                half_cnt <= '0;
                                slot <= nslot;
                                case (cur)
                                start: begin
                                        // sda falls in the middle slot with scl high
                                        scl <= (nslot != 5'd2);
                                        sda_out <= (nslot == 5'd0);
                                        sda_oe <= 1'b1;
                                end
                                stop: begin
                                        scl <= (nslot != 5'd0);
                                        sda_out <= (nslot == 5'd2); // rises with scl high
                                        sda_oe <= 1'b1;
                                end
                                write_byte: begin
                                        scl <= nslot[0];
                                        if (!nslot[0]) begin
                                                sda_oe <= (nbit != 4'd8); // ack clock released
                                                sda_out <= accept ? tx_byte[7] : shreg[6];
                                                shreg <= accept ? tx_byte : {shreg[6:0], 1'b0};
                                        end
                                end
                                read_byte_nack: begin
                                        scl <= nslot[0];
                                        sda_oe <= (nbit == 4'd8);
                                        sda_out <= 1'b1; // nack
                                        if (nslot[0] && nbit != 4'd8)
                                                shreg <= {shreg[6:0], sda_in};
                                end
                                default: ;
                                endcase
                        end else if (op != idle) begin
                                half_cnt <= half_cnt + 1'b1;
                        end
                end
        end

endmodule

// File: rtl/gap_timer.sv
`timescale 1ns/100ps

module gap_timer import cam_cfg_pkg::*; (
        input  logic clk_100kHz,
        input  logic rst_n,
        input  logic gap_start,
        input  gap_e gap_kind,
        output logic gap_done
);

        gap_cnt_t cnt;
        logic busy;

        always_ff @(posedge clk_100kHz or negedge rst_n) begin
                if (!rst_n) begin
                        cnt <= '0;
                        busy <= 1'b0;
                end else if (gap_start) begin
                        cnt <= gap_cycles[gap_kind] - 1'b1;
                        busy <= 1'b1;
                end else if (busy) begin
                        if (cnt == '0)
                                busy <= 1'b0;
                        else
                                cnt <= cnt - 1'b1;
                end
        end

        // lands exactly gap_cycles after the strobe
        assign gap_done = busy && (cnt == '0);

endmodule

// File: rtl/cfg_rom.sv
`timescale 1ns/100ps

module cfg_rom import cam_cfg_pkg::*; (
        input  cfg_idx_t  cfg_idx,
        output reg_addr_t cfg_addr,
        output reg_val_t  cfg_val
);

        // register address in the upper byte, value in the lower
        always_comb begin
                case (cfg_idx)
                5'd0:  {cfg_addr, cfg_val} = 16'h3A04;
                5'd1:  {cfg_addr, cfg_val} = 16'h40D0;
                5'd2:  {cfg_addr, cfg_val} = 16'h1214; // qvga rgb
                5'd3:  {cfg_addr, cfg_val} = 16'h3280;
                5'd4:  {cfg_addr, cfg_val} = 16'h1716;
                5'd5:  {cfg_addr, cfg_val} = 16'h1804;
                5'd6:  {cfg_addr, cfg_val} = 16'h1902;
                5'd7:  {cfg_addr, cfg_val} = 16'h1A7B;
                5'd8:  {cfg_addr, cfg_val} = 16'h0306;
                5'd9:  {cfg_addr, cfg_val} = 16'h0C00;
                5'd10: {cfg_addr, cfg_val} = 16'h1500;
                5'd11: {cfg_addr, cfg_val} = 16'h3E00;
                5'd12: {cfg_addr, cfg_val} = 16'h703A; // scaling
                5'd13: {cfg_addr, cfg_val} = 16'h7135;
                5'd14: {cfg_addr, cfg_val} = 16'h7211;
                5'd15: {cfg_addr, cfg_val} = 16'h7300;
                5'd16: {cfg_addr, cfg_val} = 16'hA202;
                5'd17: {cfg_addr, cfg_val} = 16'h1181;
                5'd18: {cfg_addr, cfg_val} = 16'h7A20; // gamma curve
                5'd19: {cfg_addr, cfg_val} = 16'h7B1C;
                5'd20: {cfg_addr, cfg_val} = 16'h7C28;
                5'd21: {cfg_addr, cfg_val} = 16'h7D3C;
                5'd22: {cfg_addr, cfg_val} = 16'h7E55;
                5'd23: {cfg_addr, cfg_val} = 16'h7F68;
                5'd24: {cfg_addr, cfg_val} = 16'h8076;
                5'd25: {cfg_addr, cfg_val} = 16'h8180;
                5'd26: {cfg_addr, cfg_val} = 16'h8288;
                5'd27: {cfg_addr, cfg_val} = 16'h838F;
                5'd28: {cfg_addr, cfg_val} = 16'h8496;
                5'd29: {cfg_addr, cfg_val} = 16'h85A3;
                5'd30: {cfg_addr, cfg_val} = 16'h86AF;
                5'd31: {cfg_addr, cfg_val} = 16'h87C4;
                endcase
        end

endmodule

// File: rtl/cam_init_seq.sv
`timescale 1ns/100ps

module cam_init_seq import sccb_pkg::*, cam_cfg_pkg::*; (
        input  logic       clk_100kHz,
        input  logic       rst_n,
        output sccb_cmd_e  cmd,
        output sccb_byte_t tx_byte,
        input  logic       done,
        input  sccb_byte_t rx_byte,
        output logic       gap_start,
        output gap_e       gap_kind,
        input  logic       gap_done,
        output cfg_idx_t   cfg_idx,
        input  reg_addr_t  cfg_addr,
        input  reg_val_t   cfg_val,
        output logic       new_data,
        output sccb_byte_t data,
        output logic       initialized
);

        typedef enum logic [3:0] {
                st_reset_wr,
                st_ver_addr,
                st_ver_read,
                st_pid_addr,
                st_pid_read,
                st_cfg,
                st_marker,
                st_final,
                st_idle
        } state_e;

        state_e state;
        logic [2:0] step; // primitive index inside a transaction
        logic [2:0] last_step;
        logic issue;
        logic is_read;
        sccb_cmd_e step_cmd;

        assign is_read = (state == st_ver_read) || (state == st_pid_read);
        assign last_step = (state == st_reset_wr || state == st_cfg) ? 3'd4 : 3'd3;

        always_comb begin
                if (step == 3'd0)
                        step_cmd = start;
                else if (step == last_step)
                        step_cmd = stop;
                else if (step == 3'd2 && is_read)
                        step_cmd = read_byte_nack;
                else
                        step_cmd = write_byte;
                if (issue)
                        cmd = step_cmd;
                else
                        cmd = idle;
        end

        always_comb begin
                case (step)
                3'd1: tx_byte = device_addr | {7'd0, is_read};
                3'd2: begin
                        case (state)
                        st_reset_wr: tx_byte = reg_com7;
                        st_ver_addr: tx_byte = reg_ver;
                        st_pid_addr: tx_byte = reg_pid;
                        default:     tx_byte = cfg_addr;
                        endcase
                end
                default: tx_byte = (state == st_reset_wr) ? reset_cmd : cfg_val;
                endcase
        end

        always_ff @(posedge clk_100kHz or negedge rst_n) begin
                if (!rst_n) begin
                        state <= st_reset_wr;
                        step <= '0;
                        issue <= 1'b1; // first start right out of reset
                        cfg_idx <= '0;
                        gap_start <= 1'b0;
                        gap_kind <= gap_byte;
                        new_data <= 1'b0;
                        data <= '0;
                        initialized <= 1'b0;
                end else begin
                        issue <= 1'b0;
                        gap_start <= 1'b0;
                        new_data <= 1'b0;
                        if (done) begin
                                if (step == last_step) begin
                                        gap_start <= 1'b1;
                                        if (state == st_reset_wr)
                                                gap_kind <= gap_settle;
                                        else if (state == st_cfg)
                                                gap_kind <= gap_cfg;
                                        else
                                                gap_kind <= gap_byte;
                                        if (is_read) begin
                                                new_data <= 1'b1;
                                                data <= rx_byte;
                                        end
                                end else begin
                                        step <= step + 3'd1;
                                        issue <= 1'b1;
                                end
                        end
                        if (gap_done) begin
                                step <= '0;
                                issue <= 1'b1;
                                case (state)
                                st_reset_wr: state <= st_ver_addr;
                                st_ver_addr: state <= st_ver_read;
                                st_ver_read: state <= st_pid_addr;
                                st_pid_addr: state <= st_pid_read;
                                st_pid_read: state <= st_cfg;
                                st_cfg: begin
                                        if (cfg_idx == cfg_idx_t'(cfg_entries - 1)) begin
                                                issue <= 1'b0;
                                                state <= st_marker;
                                                new_data <= 1'b1;
                                                data <= marker_cr;
                                                gap_start <= 1'b1;
                                                gap_kind <= gap_byte;
                                        end else begin
                                                cfg_idx <= cfg_idx + 1'b1;
                                        end
                                end
                                st_marker: begin
                                        issue <= 1'b0;
                                        state <= st_final;
                                        new_data <= 1'b1;
                                        data <= marker_lf;
                                        gap_start <= 1'b1;
                                        gap_kind <= gap_settle;
                                end
                                default: begin
                                        issue <= 1'b0;
                                        state <= st_idle;
                                        initialized <= 1'b1; // held until reset
                                end
                                endcase
                        end
                end
        end

endmodule

// File: rtl/cam_init_top.sv
`timescale 1ns/100ps

module cam_init_top import sccb_pkg::*, cam_cfg_pkg::*; (
        input  logic       clk_100kHz,
        input  logic       rst_n,
        output logic       scl,
        inout  wire        sda,
        output logic       new_data,
        output sccb_byte_t data,
        output logic       initialized
);

        sccb_cmd_e cmd;
        sccb_byte_t tx_byte;
        sccb_byte_t rx_byte;
        logic done;
        logic sda_out;
        logic sda_oe;
        logic gap_start;
        logic gap_done;
        gap_e gap_kind;
        cfg_idx_t cfg_idx;
        reg_addr_t cfg_addr;
        reg_val_t cfg_val;

        // released when oe is low and pulled up outside
        assign sda = sda_oe ? sda_out : 1'bz;

        cam_init_seq u_seq (
                .clk_100kHz(clk_100kHz),
                .rst_n(rst_n),
                .cmd(cmd),
                .tx_byte(tx_byte),
                .done(done),
                .rx_byte(rx_byte),
                .gap_start(gap_start),
                .gap_kind(gap_kind),
                .gap_done(gap_done),
                .cfg_idx(cfg_idx),
                .cfg_addr(cfg_addr),
                .cfg_val(cfg_val),
                .new_data(new_data),
                .data(data),
                .initialized(initialized)
        );

        sccb_byte_engine u_engine (
                .clk_100kHz(clk_100kHz),
                .rst_n(rst_n),
                .cmd(cmd),
                .tx_byte(tx_byte),
                .done(done),
                .rx_byte(rx_byte),
                .scl(scl),
                .sda_out(sda_out),
                .sda_oe(sda_oe),
                .sda_in(sda)
        );

        gap_timer u_gap (
                .clk_100kHz(clk_100kHz),
                .rst_n(rst_n),
                .gap_start(gap_start),
                .gap_kind(gap_kind),
                .gap_done(gap_done)
        );

        cfg_rom u_rom (
                .cfg_idx(cfg_idx),
                .cfg_addr(cfg_addr),
                .cfg_val(cfg_val)
        );

endmodule

// File: tests/sccb_target_model.sv
`timescale 1ns/100ps

module sccb_target_model (
        input  logic clk_100kHz,
        input  logic scl,
        inout  wire  sda
);

        logic [15:0] mem [0:32]; // id word followed by the expected pairs
        logic [23:0] txn = '0; // bits written by the master in this transaction
        logic [3:0] nbytes = '0;
        logic [3:0] bit_cnt = '0;
        logic [7:0] tx = '0;
        logic [7:0] reg_ptr = '0;
        logic prev_scl = 1'b1;
        logic prev_sda = 1'b1;
        logic skip_fall = 1'b0;
        logic reading = 1'b0;
        logic pull_low = 1'b0;
        int txn_count = 0;
        int mismatches = 0;
        int faults = 0;

        assign sda = pull_low ? 1'b0 : 1'bz; // open drain

        initial begin
                $readmemh("tests/cam_init_testdata.hex", mem);
        end

        task automatic close_transaction();
                string name;
                logic [27:0] exp; // byte count followed by up to three bytes
                if (txn_count == 0) begin
                        name = "soft_reset_write";
                        exp = {4'd3, 24'h421280};
                end else if (txn_count == 1 || txn_count == 3) begin
                        name = (txn_count == 1) ? "version_addr" : "pid_addr";
                        exp = {4'd2, 16'h0042, (txn_count == 1) ? 8'h0B : 8'h0A};
                end else if (txn_count == 2 || txn_count == 4) begin
                        name = (txn_count == 2) ? "version_read" : "pid_read";
                        exp = {4'd1, 24'h000043};
                end else begin
                        name = $sformatf("config_write_%0d", txn_count - 5);
                        exp = {4'd3, 8'h42, mem[txn_count - 4]};
                end
                assert (txn_count <= 36) else begin
                        $display("Unexpected transaction after the configuration table");
                        faults++;
                end
                if (txn_count <= 36) begin
                        assert ({nbytes, txn} === exp) else begin
                                $display("Mismatch %s: expected %h, actual %h",
                                         name, exp, {nbytes, txn});
                                mismatches++;
                        end
                end
                txn_count++;
        endtask

        // called on each scl fall with the level seen while scl was high
        task automatic take_bit(input logic b);
                if (bit_cnt < 4'd8) begin
                        bit_cnt = bit_cnt + 4'd1;
                        if (reading) begin
                                tx = tx << 1;
                                pull_low = (bit_cnt < 4'd8) && !tx[7];
                        end else begin
                                txn = {txn[22:0], b};
                                if (bit_cnt == 4'd8) begin
                                        nbytes = nbytes + 4'd1;
                                        if (nbytes == 4'd2)
                                                reg_ptr = txn[7:0];
                                        pull_low = 1'b1; // ack
                                end
                        end
                end else begin
                        if (reading) begin
                                assert (b === 1'b1) else begin
                                        $display("Master did not send a NACK after the read byte");
                                        faults++;
                                end
                        end
                        bit_cnt = '0;
                        pull_low = 1'b0;
                        if (!reading && nbytes == 4'd1 && txn[0]) begin
                                reading = 1'b1; // read address acked so the first data bit goes out
                                tx = (reg_ptr == 8'h0B) ? mem[0][15:8] : mem[0][7:0];
                                pull_low = !tx[7];
                        end else begin
                                reading = 1'b0;
                        end
                end
        endtask

        // bus sampled mid cycle away from the dut clock edge
        always @(negedge clk_100kHz) begin
                if (prev_scl === 1'b1 && scl === 1'b1 && prev_sda !== sda) begin
                        assert (bit_cnt == 4'd0) else begin
                                $display("Start or stop condition inside a byte");
                                faults++;
                        end
                        if (sda === 1'b0) begin
                                txn = '0;
                                nbytes = '0;
                                bit_cnt = '0;
                                skip_fall = 1'b1; // scl fall that ends the start
                        end else begin
                                close_transaction();
                        end
                end else if (prev_scl === 1'b1 && scl === 1'b0) begin
                        if (skip_fall)
                                skip_fall = 1'b0;
                        else
                                take_bit(prev_sda);
                end
                prev_scl = scl;
                prev_sda = sda;
        end

endmodule

// File: tests/tb_cam_init.sv
`timescale 1ns/100ps

module tb_cam_init import sccb_pkg::*, cam_cfg_pkg::*; ();

        localparam int max_cycles = 2 * int'(gap_cycles[gap_settle]) + (cfg_entries + 5) * 600;

        logic clk_100kHz = 1'b0;
        logic rst_n;
        logic scl;
        wire sda;
        logic new_data;
        sccb_byte_t data;
        logic initialized;
        logic [15:0] words [0:32];
        sccb_byte_t expected [0:3];
        int cycles = 0;
        int pulses = 0;
        int mismatches = 0;
        int faults = 0;
        logic bus_moved = 1'b0;
        logic seen_init = 1'b0;
        logic init_dropped = 1'b0;

        always #20 clk_100kHz = ~clk_100kHz;

        always @(negedge clk_100kHz)
                cycles++;

        pullup (sda);

        cam_init_top uut (
                .clk_100kHz(clk_100kHz),
                .rst_n(rst_n),
                .scl(scl),
                .sda(sda),
                .new_data(new_data),
                .data(data),
                .initialized(initialized)
        );

        sccb_target_model target (.clk_100kHz(clk_100kHz), .scl(scl), .sda(sda));

        task automatic compare_data(input string name, input sccb_byte_t exp, input sccb_byte_t act);
                assert (act === exp) else begin
                        $display("Mismatch %s: expected %h, actual %h", name, exp, act);
                        mismatches++;
                end
        endtask

        always @(negedge clk_100kHz) begin
                if (new_data === 1'b1) begin
                        assert (pulses < 4) else begin
                                $display("More than four new_data pulses");
                                faults++;
                        end
                        if (pulses < 4)
                                compare_data($sformatf("new_data_%0d", pulses), expected[pulses], data);
                        pulses++;
                end
                if (pulses >= 3 && !(scl === 1'b1 && sda === 1'b1))
                        bus_moved = 1'b1; // bus stays idle once the markers start
                if (seen_init && initialized !== 1'b1)
                        init_dropped = 1'b1;
                if (initialized === 1'b1)
                        seen_init = 1'b1;
        end

        initial begin
                rst_n = 1'b0;
                $readmemh("tests/cam_init_testdata.hex", words);
                expected[0] = words[0][15:8];
                expected[1] = words[0][7:0];
                expected[2] = 8'h0D;
                expected[3] = 8'h0A;
                @(posedge clk_100kHz);
                #2 compare_data("reset_state", 8'h0C, {4'h0, scl, sda, new_data, initialized});
                @(posedge clk_100kHz);
                #2 rst_n = 1'b1;
                #1 compare_data("after_reset", 8'h0C, {4'h0, scl, sda, new_data, initialized});
                while (initialized !== 1'b1 && cycles < max_cycles)
                        @(posedge clk_100kHz);
                assert (initialized === 1'b1) else begin
                        $display("Timeout, initialized did not rise within %0d cycles", max_cycles);
                        faults++;
                end
                compare_data("pulses_before_initialized", 8'd4, 8'(pulses));
                repeat (300) @(posedge clk_100kHz);
                compare_data("new_data_pulses", 8'd4, 8'(pulses));
                compare_data("transaction_count", 8'(cfg_entries + 5), 8'(target.txn_count));
                assert (!bus_moved && !init_dropped) else begin
                        $display("Bus moved or initialized dropped after the configuration table");
                        faults++;
                end
                $display("Errors: %0d mismatches, %0d faults",
                         mismatches + target.mismatches, faults + target.faults);
                if (mismatches + target.mismatches + faults + target.faults == 0)
                        $display("ALL TESTS PASSED");
                else
                        $display("SOME TESTS FAILED");
                $finish;
        end

endmodule

// File: tests/cam_init_testdata.hex
// word 0 holds the version and product-ID replies, then one register address/value pair per line
7376
3A04
40D0
1214
3280
1716
1804
1902
1A7B
0306
0C00
1500
3E00
703A
7135
7211
7300
A202
1181
7A20
7B1C
7C28
7D3C
7E55
7F68
8076
8180
8288
838F
8496
85A3
86AF
87C4

// File: files.f
common/sccb_pkg.sv
common/cam_cfg_pkg.sv
sccb/sccb_byte_engine.sv
rtl/gap_timer.sv
rtl/cfg_rom.sv
rtl/cam_init_seq.sv
rtl/cam_init_top.sv
tests/sccb_target_model.sv
tests/tb_cam_init.sv

// File: Bender.yml
package:
  name: cam_init

sources:
  - common/sccb_pkg.sv
  - common/cam_cfg_pkg.sv
  - sccb/sccb_byte_engine.sv
  - rtl/gap_timer.sv
  - rtl/cfg_rom.sv
  - rtl/cam_init_seq.sv
  - rtl/cam_init_top.sv
  - target: test
    files:
      - tests/sccb_target_model.sv
      - tests/tb_cam_init.sv
